// File: source/huff_ctrl_pkg.sv
`default_nettype none

package huff_ctrl_pkg;

    // Status code widths
    localparam int STATE_W = 4;
    localparam int FIN_W   = 4;
    localparam int OP_W    = 3;

    // Stage codes carried on state_en
    localparam logic [STATE_W-1:0] ST_IDLE  = 4'd0;
    localparam logic [STATE_W-1:0] ST_HIST  = 4'd1;  // Histogram
    localparam logic [STATE_W-1:0] ST_FLV   = 4'd2;  // Frequency list
    localparam logic [STATE_W-1:0] ST_HTREE = 4'd3;  // Tree build
    localparam logic [STATE_W-1:0] ST_CBS   = 4'd4;  // Codebook synthesis
    localparam logic [STATE_W-1:0] ST_TRN   = 4'd5;  // Translation
    localparam logic [STATE_W-1:0] ST_SPI   = 4'd6;  // SPI output
    localparam logic [STATE_W-1:0] ST_ERROR = 4'd7;
    localparam logic [STATE_W-1:0] ST_DONE  = 4'd8;

    // Outcome codes
    localparam logic [FIN_W-1:0] FIN_TIMEOUT = 4'd8;  // Completed count replaced on overrun
    localparam logic [OP_W-1:0]  OP_ERR      = 3'd7;  // Last-stage code after a stage error

    // Watchdog budget per stage, in cycles
    localparam int STAGE_LIMIT = 64;
    localparam int WD_W        = 7;  // Must hold STAGE_LIMIT

endpackage

`default_nettype wire

// File: source/seg_glyph_pkg.sv
`default_nettype none

package seg_glyph_pkg;

    // Segment order {dp, g, f, e, d, c, b, a}
    localparam logic [7:0] GL_BLANK = 8'b0000_0000;
    localparam logic [7:0] GL_DASH  = 8'b0100_0000;  // Middle bar only
    localparam logic [7:0] GL_RUN   = 8'b0000_0001;  // Top bar, busy marker on ss7

    localparam logic [7:0] GL_I = 8'b0000_0110;
    localparam logic [7:0] GL_D = 8'b0101_1110;
    localparam logic [7:0] GL_L = 8'b0011_1000;
    localparam logic [7:0] GL_E = 8'b0111_1001;
    localparam logic [7:0] GL_H = 8'b0111_0110;
    localparam logic [7:0] GL_S = 8'b0110_1101;
    localparam logic [7:0] GL_T = 8'b0111_1000;
    localparam logic [7:0] GL_F = 8'b0111_0001;
    localparam logic [7:0] GL_V = 8'b0011_1110;
    localparam logic [7:0] GL_R = 8'b0101_0000;  // Lower-case r
    localparam logic [7:0] GL_C = 8'b0011_1001;
    localparam logic [7:0] GL_B = 8'b0111_1100;  // Lower-case b
    localparam logic [7:0] GL_N = 8'b0101_0100;  // Lower-case n
    localparam logic [7:0] GL_P = 8'b0111_0011;
    localparam logic [7:0] GL_O = 8'b0011_1111;

endpackage

`default_nettype wire

// File: source/stage_watchdog.sv
`timescale 1ns/1ps
`default_nettype none

module stage_watchdog import huff_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stage_active,
    input  logic [STATE_W-1:0] state_en,
    output logic               overrun
);

    logic [STATE_W-1:0] last_state;
    logic [WD_W-1:0]    cnt;  // Cycles already spent in the current stage
    logic [WD_W-1:0]    cnt_nxt;
    logic               same_stage;

    assign same_stage = (state_en == last_state);

    always_comb begin
        if (!same_stage) begin
            cnt_nxt = WD_W'(1);  // First cycle of a new stage
        end else if (cnt == WD_W'(STAGE_LIMIT)) begin
            cnt_nxt = cnt;  // Hold at the limit
        end else begin
            cnt_nxt = cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_state <= ST_IDLE;
            cnt        <= '0;
        end else begin
            last_state <= state_en;
            cnt        <= cnt_nxt;
        end
    end

    // Fires in the STAGE_LIMIT-th cycle of an active stage, once
    assign overrun = stage_active && same_stage && (cnt == WD_W'(STAGE_LIMIT - 1));

endmodule

`default_nettype wire

// File: source/huff_stage_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module huff_stage_fsm import huff_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               stage_done,
    input  logic               stage_err,
    input  logic               cont_en,
    input  logic               overrun,
    output logic [STATE_W-1:0] state_en,
    output logic [FIN_W-1:0]   fin_state,
    output logic [OP_W-1:0]    op_fin,
    output logic               stage_active
);

    logic [STATE_W-1:0] state_nxt;
    logic [FIN_W-1:0]   fin_nxt;
    logic [OP_W-1:0]    op_nxt;

    assign stage_active = (state_en >= ST_HIST) && (state_en <= ST_SPI);

    always_comb begin
        state_nxt = state_en;
        fin_nxt   = fin_state;
        op_nxt    = op_fin;

        case (state_en)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_HIST;
                end
            end

            ST_HIST, ST_FLV, ST_HTREE, ST_CBS, ST_TRN, ST_SPI: begin
                if (stage_err) begin
                    state_nxt = ST_ERROR;
                    op_nxt    = OP_ERR;
                end else if (overrun) begin
                    state_nxt = ST_ERROR;
                    fin_nxt   = FIN_TIMEOUT;
                end else if (stage_done) begin
                    state_nxt = (state_en == ST_SPI) ? ST_DONE : state_en + 1'b1;
                    fin_nxt   = fin_state + 1'b1;
                    op_nxt    = OP_W'(state_en - ST_HIST);  // Histogram is index 0
                end
            end

            ST_DONE, ST_ERROR: begin
                if (cont_en) begin
                    state_nxt = ST_IDLE;
                    fin_nxt   = '0;
                    op_nxt    = '0;
                end
            end

            default: begin
                // Unused codes fall back to idle
                state_nxt = ST_IDLE;
                fin_nxt   = '0;
                op_nxt    = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_en  <= ST_IDLE;
            fin_state <= '0;
            op_fin    <= '0;
        end else begin
            state_en  <= state_nxt;
            fin_state <= fin_nxt;
            op_fin    <= op_nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/huff_indicator.sv
`timescale 1ns/1ps
`default_nettype none

module huff_indicator import huff_ctrl_pkg::*, seg_glyph_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [STATE_W-1:0] state_en,
    input  logic [FIN_W-1:0]   fin_state,
    input  logic [OP_W-1:0]    op_fin,
    output logic [7:0]         left,
    output logic [7:0]         right,
    output logic [7:0]         ss7,
    output logic [7:0]         ss6,
    output logic [7:0]         ss5,
    output logic [7:0]         ss4,
    output logic [7:0]         ss3,
    output logic [7:0]         ss2,
    output logic [7:0]         ss1,
    output logic [7:0]         ss0,
    output logic               red,
    output logic               green,
    output logic               blue
);

    logic               in_vld;  // Set once the input stage holds a real code
    logic [STATE_W-1:0] state_q;
    logic [FIN_W-1:0]   fin_q;
    logic [OP_W-1:0]    op_q;

    logic [63:0] glyphs;  // {ss7 .. ss0}
    logic [7:0]  left_d;
    logic [7:0]  right_d;
    logic        red_d;
    logic        green_d;
    logic        blue_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_vld  <= 1'b0;
            state_q <= ST_IDLE;
            fin_q   <= '0;
            op_q    <= '0;
        end else begin
            in_vld  <= 1'b1;
            state_q <= state_en;
            fin_q   <= fin_state;
            op_q    <= op_fin;
        end
    end

    always_comb begin
        case (state_q)
            ST_IDLE:  glyphs = {GL_BLANK, GL_BLANK, GL_I, GL_D, GL_L, GL_E, GL_BLANK, GL_BLANK};
            ST_HIST:  glyphs = {GL_RUN, GL_BLANK, GL_H, GL_I, GL_S, GL_T, GL_BLANK, GL_BLANK};
            ST_FLV:   glyphs = {GL_RUN, GL_BLANK, GL_BLANK, GL_F, GL_L, GL_V, GL_BLANK, GL_BLANK};
            ST_HTREE: glyphs = {GL_RUN, GL_BLANK, GL_H, GL_T, GL_R, GL_E, GL_E, GL_BLANK};
            ST_CBS:   glyphs = {GL_RUN, GL_BLANK, GL_BLANK, GL_C, GL_B, GL_S, GL_BLANK, GL_BLANK};
            ST_TRN:   glyphs = {GL_RUN, GL_BLANK, GL_BLANK, GL_T, GL_R, GL_N, GL_BLANK, GL_BLANK};
            ST_SPI:   glyphs = {GL_RUN, GL_BLANK, GL_BLANK, GL_S, GL_P, GL_I, GL_BLANK, GL_BLANK};
            ST_ERROR: glyphs = {GL_RUN, GL_E, GL_R, GL_R, GL_O, GL_R, GL_BLANK, GL_BLANK};
            ST_DONE:  glyphs = {GL_RUN, GL_BLANK, GL_D, GL_O, GL_N, GL_E, GL_BLANK, GL_BLANK};
            default:  glyphs = {8{GL_DASH}};  // Unknown stage code
        endcase

        // Last finished stage, histogram on bit 7
        if (op_q == OP_ERR) begin
            left_d = 8'hff;
        end else begin
            left_d = 8'h80 >> op_q;
        end

        // Completed count, one-hot up to seven
        if (fin_q < FIN_TIMEOUT) begin
            right_d = 8'h80 >> fin_q;
        end else begin
            right_d = 8'h00;
        end

        red_d   = (fin_q == FIN_TIMEOUT) || (op_q == OP_ERR) || (state_q == ST_ERROR);
        green_d = !red_d && (state_q == ST_DONE);
        blue_d  = !red_d && !green_d;

        // Dark until the first code has passed the input stage
        if (!in_vld) begin
            glyphs  = '0;
            left_d  = '0;
            right_d = '0;
            red_d   = 1'b0;
            green_d = 1'b0;
            blue_d  = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0} <= '0;
            left  <= '0;
            right <= '0;
            red   <= 1'b0;
            green <= 1'b0;
            blue  <= 1'b0;
        end else begin
            {ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0} <= glyphs;
            left  <= left_d;
            right <= right_d;
            red   <= red_d;
            green <= green_d;
            blue  <= blue_d;
        end
    end

endmodule

`default_nettype wire

// File: source/huff_status_top.sv
`timescale 1ns/1ps
`default_nettype none

module huff_status_top import huff_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       stage_done,
    input  logic       stage_err,
    input  logic       cont_en,
    output logic [7:0] left,
    output logic [7:0] right,
    output logic [7:0] ss7,
    output logic [7:0] ss6,
    output logic [7:0] ss5,
    output logic [7:0] ss4,
    output logic [7:0] ss3,
    output logic [7:0] ss2,
    output logic [7:0] ss1,
    output logic [7:0] ss0,
    output logic       red,
    output logic       green,
    output logic       blue
);

    logic [STATE_W-1:0] state_en;
    logic [FIN_W-1:0]   fin_state;
    logic [OP_W-1:0]    op_fin;
    logic               stage_active;
    logic               overrun;  // From watchdog back into the sequencer

    huff_stage_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .stage_done   (stage_done),
        .stage_err    (stage_err),
        .cont_en      (cont_en),
        .overrun      (overrun),
        .state_en     (state_en),
        .fin_state    (fin_state),
        .op_fin       (op_fin),
        .stage_active (stage_active)
    );

    stage_watchdog u_wd (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage_active (stage_active),
        .state_en     (state_en),
        .overrun      (overrun)
    );

    huff_indicator u_ind (
        .clk       (clk),
        .rst_n     (rst_n),
        .state_en  (state_en),
        .fin_state (fin_state),
        .op_fin    (op_fin),
        .left      (left),
        .right     (right),
        .ss7       (ss7),
        .ss6       (ss6),
        .ss5       (ss5),
        .ss4       (ss4),
        .ss3       (ss3),
        .ss2       (ss2),
        .ss1       (ss1),
        .ss0       (ss0),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

`default_nettype wire

// File: tb/huff_status_assert.sv
`timescale 1ns/1ps
`default_nettype none

module huff_status_assert import huff_ctrl_pkg::*, seg_glyph_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               red,
    input  logic               green,
    input  logic               blue,
    input  logic [7:0]         ss6,
    input  logic               overrun,
    input  logic [STATE_W-1:0] state_en
);

    int unsigned fail_cnt = 0;

    // Red lamp only with the ERROR glyphs
    lamp_matches_error: assert property (@(posedge clk) disable iff (!rst_n)
        red == (ss6 == GL_E))
    else begin
        fail_cnt++;
        $error("Red lamp does not match the ERROR glyphs");
    end

    // Watchdog fires once per stage
    overrun_single: assert property (@(posedge clk) disable iff (!rst_n)
        overrun |=> !overrun)
    else begin
        fail_cnt++;
        $error("overrun high for two cycles in a row");
    end

    state_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        state_en <= ST_DONE)
    else begin
        fail_cnt++;
        $error("state_en above ST_DONE");
    end

endmodule

`default_nettype wire

// File: tb/huff_status_tb.sv
`timescale 1ns/1ps
`default_nettype none

module huff_status_tb
    import huff_ctrl_pkg::*, seg_glyph_pkg::*;
();

    localparam int          CLK_PERIOD     = 40;
    localparam int          RESET_CYCLES   = 2;
    localparam int          RUN_CYCLES     = 3000;
    localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 6;
    localparam int          STALL_PERIOD   = 500;
    localparam int          STALL_LEN      = STAGE_LIMIT + 36;  // Long enough to force overrun
    localparam logic [31:0] SEED           = 32'd78675;

    logic clk = 1'b0;
    logic rst_n;
    logic start;
    logic stage_done;
    logic stage_err;
    logic cont_en;

    logic [7:0] left;
    logic [7:0] right;
    logic [7:0] ss7;
    logic [7:0] ss6;
    logic [7:0] ss5;
    logic [7:0] ss4;
    logic [7:0] ss3;
    logic [7:0] ss2;
    logic [7:0] ss1;
    logic [7:0] ss0;
    logic       red;
    logic       green;
    logic       blue;

    // Reference sequencer state
    logic [STATE_W-1:0] m_state;
    logic [FIN_W-1:0]   m_fin;
    logic [OP_W-1:0]    m_op;
    int                 m_age;  // Cycles spent in the current state

    // Indicator input stage of the model
    logic               q_vld;
    logic [STATE_W-1:0] q_state;
    logic [FIN_W-1:0]   q_fin;
    logic [OP_W-1:0]    q_op;

    logic [63:0] exp_seg;
    logic [7:0]  exp_left;
    logic [7:0]  exp_right;
    logic        exp_red;
    logic        exp_green;
    logic        exp_blue;

    logic [31:0] rng;
    int          check_cnt = 0;
    int          err_cnt = 0;
    int          cycle_cnt = 0;
    int          n_done = 0;
    int          n_timeout = 0;
    int          n_stage_err = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    huff_status_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .stage_done (stage_done),
        .stage_err  (stage_err),
        .cont_en    (cont_en),
        .left       (left),
        .right      (right),
        .ss7        (ss7),
        .ss6        (ss6),
        .ss5        (ss5),
        .ss4        (ss4),
        .ss3        (ss3),
        .ss2        (ss2),
        .ss1        (ss1),
        .ss0        (ss0),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    bind huff_status_top huff_status_assert u_assert (
        .clk      (clk),
        .rst_n    (rst_n),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .ss6      (ss6),
        .overrun  (overrun),
        .state_en (state_en)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Digits ss7 down to ss0 for one stage code
    function automatic logic [63:0] stage_glyphs(input logic [STATE_W-1:0] st);
        case (st)
            ST_IDLE:  return {GL_BLANK, GL_BLANK, GL_I, GL_D, GL_L, GL_E, GL_BLANK, GL_BLANK};
            ST_HIST:  return {GL_RUN, GL_BLANK, GL_H, GL_I, GL_S, GL_T, GL_BLANK, GL_BLANK};
            ST_FLV:   return {GL_RUN, GL_BLANK, GL_BLANK, GL_F, GL_L, GL_V, GL_BLANK, GL_BLANK};
            ST_HTREE: return {GL_RUN, GL_BLANK, GL_H, GL_T, GL_R, GL_E, GL_E, GL_BLANK};
            ST_CBS:   return {GL_RUN, GL_BLANK, GL_BLANK, GL_C, GL_B, GL_S, GL_BLANK, GL_BLANK};
            ST_TRN:   return {GL_RUN, GL_BLANK, GL_BLANK, GL_T, GL_R, GL_N, GL_BLANK, GL_BLANK};
            ST_SPI:   return {GL_RUN, GL_BLANK, GL_BLANK, GL_S, GL_P, GL_I, GL_BLANK, GL_BLANK};
            ST_ERROR: return {GL_RUN, GL_E, GL_R, GL_R, GL_O, GL_R, GL_BLANK, GL_BLANK};
            ST_DONE:  return {GL_RUN, GL_BLANK, GL_D, GL_O, GL_N, GL_E, GL_BLANK, GL_BLANK};
            default:  return {8{GL_DASH}};
        endcase
    endfunction

    // Position 0 lights bit 7
    function automatic logic [7:0] bar_onehot(input logic [3:0] pos);
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = (pos == 4'(7 - i));
        end
        return b;
    endfunction

    always @(posedge clk) begin : ref_model
        logic               active;
        logic               ovr;
        logic [STATE_W-1:0] nxt_state;
        logic [FIN_W-1:0]   nxt_fin;
        logic [OP_W-1:0]    nxt_op;

        if (!rst_n) begin
            m_state = ST_IDLE;
            m_fin   = '0;
            m_op    = '0;
            m_age   = 0;
            q_vld   = 1'b0;
            q_state = ST_IDLE;
            q_fin   = '0;
            q_op    = '0;
            exp_seg = '0;
            {exp_left, exp_right, exp_red, exp_green, exp_blue} = '0;
        end else begin
            // Output registers follow the input stage of the previous edge
            if (q_vld) begin
                exp_seg   = stage_glyphs(q_state);
                exp_left  = (q_op == OP_ERR) ? 8'hff : bar_onehot({1'b0, q_op});
                exp_right = (q_fin < FIN_TIMEOUT) ? bar_onehot(q_fin) : 8'h00;
                exp_red   = (q_fin == FIN_TIMEOUT) || (q_op == OP_ERR) || (q_state == ST_ERROR);
                exp_green = !exp_red && (q_state == ST_DONE);
                exp_blue  = !exp_red && !exp_green;
            end else begin
                exp_seg = '0;
                {exp_left, exp_right, exp_red, exp_green, exp_blue} = '0;
            end
            q_vld   = 1'b1;
            q_state = m_state;
            q_fin   = m_fin;
            q_op    = m_op;

            active    = (m_state >= ST_HIST) && (m_state <= ST_SPI);
            ovr       = active && (m_age == STAGE_LIMIT - 1);
            nxt_state = m_state;
            nxt_fin   = m_fin;
            nxt_op    = m_op;
            if (m_state == ST_IDLE) begin
                if (start) begin
                    nxt_state = ST_HIST;
                end
            end else if (active) begin
                if (stage_err) begin
                    nxt_state = ST_ERROR;
                    nxt_op    = OP_ERR;
                    n_stage_err++;
                end else if (ovr) begin
                    nxt_state = ST_ERROR;
                    nxt_fin   = FIN_TIMEOUT;
                    n_timeout++;
                end else if (stage_done) begin
                    nxt_state = (m_state == ST_SPI) ? ST_DONE : m_state + 4'd1;
                    nxt_op    = m_fin[2:0];  // Finished stage index equals count so far
                    nxt_fin   = m_fin + 4'd1;
                    if (m_state == ST_SPI) begin
                        n_done++;
                    end
                end
            end else if (cont_en) begin
                nxt_state = ST_IDLE;
                nxt_fin   = '0;
                nxt_op    = '0;
            end

            if (nxt_state != m_state) begin
                m_age = 0;
            end else if (m_age < 255) begin
                m_age++;
            end
            m_state = nxt_state;
            m_fin   = nxt_fin;
            m_op    = nxt_op;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL t=%0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_value("ss7..ss0", {ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0}, exp_seg);
        check_value("left", 64'(left), 64'(exp_left));
        check_value("right", 64'(right), 64'(exp_right));
        check_value("rgb", 64'({red, green, blue}), 64'({exp_red, exp_green, exp_blue}));
    endtask

    always @(posedge clk) begin : run_limit
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin : stimulus
        logic stall;

        rng        = SEED;
        rst_n      = 1'b0;
        start      = 1'b0;
        stage_done = 1'b0;
        stage_err  = 1'b0;
        cont_en    = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_outputs();
        end
        rst_n = 1'b1;

        for (int i = 0; i < RUN_CYCLES; i++) begin
            @(negedge clk);
            compare_outputs();
            rng   = next_random(rng);
            stall = (i % STALL_PERIOD) >= (STALL_PERIOD - STALL_LEN);
            start      = (rng[2:0] == 3'd0);
            stage_done = !stall && (rng[6:5] == 2'd0);  // About 1 in 4
            stage_err  = !stall && (rng[16:11] == 6'd0);  // About 1 in 64
            cont_en    = (rng[23:21] == 3'd0);
        end

        $display(
            "Checks %0d, errors %0d, assert errors %0d, runs %0d, timeouts %0d, stage errs %0d",
            check_cnt, err_cnt, dut0.u_assert.fail_cnt, n_done, n_timeout, n_stage_err);
        if (err_cnt == 0 && dut0.u_assert.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: huff_status.f
source/huff_ctrl_pkg.sv
source/seg_glyph_pkg.sv
source/stage_watchdog.sv
source/huff_stage_fsm.sv
source/huff_indicator.sv
source/huff_status_top.sv
tb/huff_status_assert.sv
tb/huff_status_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= huff_status_tb
FILELIST  ?= huff_status.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Test failures found

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulation exited with status $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
